/* hdl/apb_pkg.sv */
/*
  APB bus-side widths and the request/response structs between the
  slave adapter and the register controller. One build width only.
  Field order of both structs is fixed; the testbench may rely on it.
*/

package apb_pkg;

   // bus widths
   localparam int ADDR_W = 12;
   localparam int DATA_W = 32;
   localparam int USER_W = 4;

   // registered request toward the controller, 49 bits
   typedef struct packed {
      logic              write;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      // bit 0 marks a privileged master
      logic [USER_W-1:0] user;
   } comp_req_t;

   // controller answer, plain levels, 34 bits
   typedef struct packed {
      // stall the access phase while set
      logic              hold;
      logic              slverr;
      logic [DATA_W-1:0] rdata;
   } comp_rsp_t;

endpackage

/* hdl/csum_pkg.sv */
/*
  Register map and engine interface types for the Fletcher-16 block.
  Offsets are word aligned; the low two address bits are ignored.
  The four scratch words sit at 0x010..0x01C and must stay 16-byte aligned.
*/

package csum_pkg;

   // register offsets
   localparam logic [apb_pkg::ADDR_W-1:0] OFS_CTRL   = 12'h000;
   localparam logic [apb_pkg::ADDR_W-1:0] OFS_DATA   = 12'h004;
   localparam logic [apb_pkg::ADDR_W-1:0] OFS_RESULT = 12'h008;
   localparam logic [apb_pkg::ADDR_W-1:0] OFS_STATUS = 12'h00C;
   localparam logic [apb_pkg::ADDR_W-1:0] OFS_SCR0   = 12'h010;

   // scratch bank size and index width
   localparam int NUM_SCR   = 4;
   localparam int SCR_IDX_W = $clog2(NUM_SCR);

   // engine folds one byte per cycle
   localparam int BYTES_PER_WORD = 4;
   localparam int BYTE_CNT_W     = $clog2(BYTES_PER_WORD);

   // CTRL register layout
   typedef struct packed {
      logic [30:0] reserved;
      logic        clear;
   } ctrl_fields_t;

   // one written word, seen raw or as CTRL fields
   typedef union packed {
      logic [31:0]  raw;
      ctrl_fields_t f;
   } ctrl_word_u;

   // controller to engine, start and clear are one-cycle pulses
   typedef struct packed {
      logic        start;
      logic        clear;
      logic [31:0] word;
   } eng_cmd_t;

   // engine to controller
   typedef struct packed {
      logic        busy;
      logic [7:0]  sum1;
      logic [7:0]  sum2;
      logic [15:0] count;
   } eng_stat_t;

endpackage

/* hdl/apb_slv_sif.sv */
/*
  APB slave adapter. Setup-phase fields are registered into req and dv
  stays high from setup until the access phase completes with PREADY.
  Wait states come only from rsp.hold. An access phase without a
  preceding setup is answered with PSLVERR. PSTRB is not supported.
*/

`timescale 1ns/1ns

module apb_slv_sif (
   input  logic                        PCLK,
   input  logic                        PRESETn,
   input  logic [apb_pkg::ADDR_W-1:0]  PADDR,
   input  logic                        PSEL,
   input  logic                        PENABLE,
   input  logic                        PWRITE,
   input  logic [apb_pkg::DATA_W-1:0]  PWDATA,
   input  logic [apb_pkg::USER_W-1:0]  PAUSER,
   output logic                        PREADY,
   output logic                        PSLVERR,
   output logic [apb_pkg::DATA_W-1:0]  PRDATA,
   output logic                        dv,
   output apb_pkg::comp_req_t          req,
   input  apb_pkg::comp_rsp_t          rsp
);

   logic setup_phase;
   logic access_phase;
   logic valid_access;

   // bus phase decode
   assign setup_phase  = PSEL & ~PENABLE;
   assign access_phase = PSEL & PENABLE;
   // access that followed a registered setup
   assign valid_access = dv & access_phase;

   always_ff @(posedge PCLK or negedge PRESETn) begin
      if (!PRESETn) begin
         req <= '0;
         dv  <= 1'b0;
      end else begin
         // capture the request fields at setup
         if (setup_phase) begin
            req.addr  <= PADDR;
            req.write <= PWRITE;
            req.user  <= PAUSER;
         end
         // read transfers keep the previous write data
         if (setup_phase && PWRITE) begin
            req.wdata <= PWDATA;
         end
         // set at setup, drop once the access completes
         if (setup_phase) begin
            dv <= 1'b1;
         end else if (access_phase && PREADY) begin
            dv <= 1'b0;
         end
      end
   end

   // wait states only while the component holds
   assign PREADY  = valid_access ? ~rsp.hold : 1'b1;
   // access without setup is a protocol error
   assign PSLVERR = valid_access ? rsp.slverr : access_phase;
   assign PRDATA  = rsp.rdata;

endmodule

/* hdl/csum_reg_ctrl.sv */
/*
  Register controller. Decodes one request per transfer, holds the bus
  while the engine is busy for DATA writes, RESULT reads and CTRL writes,
  and commits in the single cycle where dv is high and hold is low.
  Erroring transfers are never held and have no side effect.
*/

`timescale 1ns/1ns

module csum_reg_ctrl (
   input  logic                                  PCLK,
   input  logic                                  PRESETn,
   input  logic                                  dv,
   input  apb_pkg::comp_req_t                    req,
   output apb_pkg::comp_rsp_t                    rsp,
   output csum_pkg::eng_cmd_t                    eng_cmd,
   input  csum_pkg::eng_stat_t                   eng_stat,
   output logic                                  scr_we,
   output logic [csum_pkg::SCR_IDX_W-1:0]        scr_idx,
   output logic [apb_pkg::DATA_W-1:0]            scr_wdata,
   input  logic [csum_pkg::NUM_SCR-1:0][apb_pkg::DATA_W-1:0] scr_words
);

   logic [apb_pkg::ADDR_W-3:0] word_ofs;
   logic                       is_ctrl;
   logic                       is_data;
   logic                       is_result;
   logic                       is_status;
   logic                       is_scr;
   logic                       unmapped;
   logic                       err;
   logic                       hold;
   logic                       commit;
   logic                       privileged;
   csum_pkg::ctrl_word_u       wv;

   // word offset, byte lanes ignored
   assign word_ofs = req.addr[apb_pkg::ADDR_W-1:2];

   // register select
   assign is_ctrl   = (word_ofs == csum_pkg::OFS_CTRL[apb_pkg::ADDR_W-1:2]);
   assign is_data   = (word_ofs == csum_pkg::OFS_DATA[apb_pkg::ADDR_W-1:2]);
   assign is_result = (word_ofs == csum_pkg::OFS_RESULT[apb_pkg::ADDR_W-1:2]);
   assign is_status = (word_ofs == csum_pkg::OFS_STATUS[apb_pkg::ADDR_W-1:2]);
   // scratch window of NUM_SCR words from OFS_SCR0
   assign is_scr    = (word_ofs >= csum_pkg::OFS_SCR0[apb_pkg::ADDR_W-1:2]) &&
                      (word_ofs < csum_pkg::OFS_SCR0[apb_pkg::ADDR_W-1:2] + csum_pkg::NUM_SCR);
   assign unmapped  = ~(is_ctrl | is_data | is_result | is_status | is_scr);

   assign privileged = req.user[0];

   // illegal direction, unmapped or unprivileged CTRL write
   assign err = unmapped
              | (~req.write & (is_data | is_ctrl))
              | (req.write & (is_result | is_status))
              | (req.write & is_ctrl & ~privileged);

   // stall until the engine is idle, STATUS and scratch never wait
   assign hold = dv & eng_stat.busy & ~err &
                 ((req.write & is_data) | (~req.write & is_result) |
                  (req.write & is_ctrl));

   // the one cycle in which side effects happen
   assign commit = dv & ~hold & ~err;

   // same write data seen as raw word or CTRL fields
   assign wv.raw = req.wdata;

   // engine pulses, registered in the engine at the commit edge
   assign eng_cmd.start = commit & req.write & is_data;
   assign eng_cmd.clear = commit & req.write & is_ctrl & wv.f.clear;
   assign eng_cmd.word  = wv.raw;

   // scratch write, base is 16-byte aligned so addr[3:2] is the index
   assign scr_we    = commit & req.write & is_scr;
   assign scr_idx   = req.addr[2 +: csum_pkg::SCR_IDX_W];
   assign scr_wdata = wv.raw;

   // read mux
   always_comb begin
      rsp.rdata = '0;
      if (!req.write) begin
         if (is_result) begin
            // held while busy, so sums are final here
            rsp.rdata = {16'h0000, eng_stat.sum2, eng_stat.sum1};
         end else if (is_status) begin
            rsp.rdata = {eng_stat.busy, 15'h0000, eng_stat.count};
         end else if (is_scr) begin
            rsp.rdata = scr_words[scr_idx];
         end
      end
   end

   assign rsp.hold   = hold;
   assign rsp.slverr = err;

endmodule

/* hdl/fletcher_engine.sv */
/*
  Fletcher-16 engine. A start pulse latches a 32-bit word, then one byte
  is folded per cycle, least significant first, both sums mod 255.
  Busy lasts exactly BYTES_PER_WORD cycles; count bumps when it ends.
  Start and clear are only issued while idle.
*/

`timescale 1ns/1ns

module fletcher_engine (
   input  logic                PCLK,
   input  logic                PRESETn,
   input  csum_pkg::eng_cmd_t  cmd,
   output csum_pkg::eng_stat_t stat
);

   logic [31:0]                     word_q;
   logic [csum_pkg::BYTE_CNT_W-1:0] byte_cnt;
   logic [7:0]                      sum1_nxt;
   logic [7:0]                      sum2_nxt;
   logic                            last_byte;

   // a + b mod 255, both inputs below 255
   function automatic logic [7:0] add_mod255(input logic [7:0] a, input logic [7:0] b);
      logic [8:0] s;
      s = {1'b0, a} + {1'b0, b};
      if (s >= 9'd255) begin
         s = s - 9'd255;
      end
      return s[7:0];
   endfunction

   // next sums from the current low byte
   assign sum1_nxt  = add_mod255(stat.sum1, word_q[7:0]);
   assign sum2_nxt  = add_mod255(stat.sum2, sum1_nxt);
   assign last_byte = (byte_cnt == csum_pkg::BYTE_CNT_W'(csum_pkg::BYTES_PER_WORD - 1));

   // word shift register
   always_ff @(posedge PCLK) begin
      if (cmd.start) begin
         word_q <= cmd.word;
      end else if (stat.busy) begin
         word_q <= word_q >> 8;
      end
   end

   always_ff @(posedge PCLK or negedge PRESETn) begin
      if (!PRESETn) begin
         stat     <= '0;
         byte_cnt <= '0;
      end else if (cmd.clear) begin
         stat.sum1  <= '0;
         stat.sum2  <= '0;
         stat.count <= '0;
      end else if (cmd.start) begin
         stat.busy <= 1'b1;
         byte_cnt  <= '0;
      end else if (stat.busy) begin
         stat.sum1 <= sum1_nxt;
         stat.sum2 <= sum2_nxt;
         byte_cnt  <= byte_cnt + 1'b1;
         // word done after the fourth byte
         if (last_byte) begin
            stat.busy  <= 1'b0;
            stat.count <= stat.count + 16'd1;
         end
      end
   end

endmodule

/* hdl/scratch_regs.sv */
/*
  Scratch register bank, four 32-bit words with an indexed write.
  All words read in parallel; the controller picks one.
  Contents reset to zero.
*/

`timescale 1ns/1ns

module scratch_regs (
   input  logic                                              PCLK,
   input  logic                                              PRESETn,
   input  logic                                              we,
   input  logic [csum_pkg::SCR_IDX_W-1:0]                    idx,
   input  logic [apb_pkg::DATA_W-1:0]                        wdata,
   output logic [csum_pkg::NUM_SCR-1:0][apb_pkg::DATA_W-1:0] words
);

   always_ff @(posedge PCLK or negedge PRESETn) begin
      if (!PRESETn) begin
         words <= '0;
      end else if (we) begin
         // one word per commit
         words[idx] <= wdata;
      end
   end

endmodule

/* hdl/apb_csum_top.sv */
/*
  APB Fletcher-16 checksum peripheral with four scratch registers.
  PPROT is accepted for interface compatibility and ignored.
  PAUSER bit 0 must be set to write CTRL. No PSTRB, DMA or interrupts.
*/

`timescale 1ns/1ns

module apb_csum_top (
   input  logic                       PCLK,
   input  logic                       PRESETn,
   input  logic [apb_pkg::ADDR_W-1:0] PADDR,
   input  logic [2:0]                 PPROT,
   input  logic                       PSEL,
   input  logic                       PENABLE,
   input  logic                       PWRITE,
   input  logic [apb_pkg::DATA_W-1:0] PWDATA,
   input  logic [apb_pkg::USER_W-1:0] PAUSER,
   output logic                       PREADY,
   output logic                       PSLVERR,
   output logic [apb_pkg::DATA_W-1:0] PRDATA
);

   logic                                              dv;
   apb_pkg::comp_req_t                                req;
   apb_pkg::comp_rsp_t                                rsp;
   csum_pkg::eng_cmd_t                                eng_cmd;
   csum_pkg::eng_stat_t                               eng_stat;
   logic                                              scr_we;
   logic [csum_pkg::SCR_IDX_W-1:0]                    scr_idx;
   logic [apb_pkg::DATA_W-1:0]                        scr_wdata;
   logic [csum_pkg::NUM_SCR-1:0][apb_pkg::DATA_W-1:0] scr_words;

   // bus adapter
   apb_slv_sif u_sif (
      .PCLK    (PCLK),
      .PRESETn (PRESETn),
      .PADDR   (PADDR),
      .PSEL    (PSEL),
      .PENABLE (PENABLE),
      .PWRITE  (PWRITE),
      .PWDATA  (PWDATA),
      .PAUSER  (PAUSER),
      .PREADY  (PREADY),
      .PSLVERR (PSLVERR),
      .PRDATA  (PRDATA),
      .dv      (dv),
      .req     (req),
      .rsp     (rsp)
   );

   // register decode and commit
   csum_reg_ctrl u_ctrl (
      .PCLK      (PCLK),
      .PRESETn   (PRESETn),
      .dv        (dv),
      .req       (req),
      .rsp       (rsp),
      .eng_cmd   (eng_cmd),
      .eng_stat  (eng_stat),
      .scr_we    (scr_we),
      .scr_idx   (scr_idx),
      .scr_wdata (scr_wdata),
      .scr_words (scr_words)
   );

   // checksum datapath
   fletcher_engine u_engine (
      .PCLK    (PCLK),
      .PRESETn (PRESETn),
      .cmd     (eng_cmd),
      .stat    (eng_stat)
   );

   scratch_regs u_scratch (
      .PCLK    (PCLK),
      .PRESETn (PRESETn),
      .we      (scr_we),
      .idx     (scr_idx),
      .wdata   (scr_wdata),
      .words   (scr_words)
   );

endmodule

/* dv/csum_assert.sv */
/*
  APB protocol checks for the slave adapter, bound into every apb_slv_sif.
  Assumes the master holds PSEL and PENABLE through the completing edge.
*/

`timescale 1ns/1ns

module csum_assert (
   input logic                       PCLK,
   input logic                       PRESETn,
   input logic                       PSEL,
   input logic                       PENABLE,
   input logic [apb_pkg::ADDR_W-1:0] PADDR,
   input logic                       PWRITE,
   input logic                       PREADY,
   input logic                       dv
);

   int access_fails = 0;
   int stable_fails = 0;
   int ready_fails  = 0;
   int fail_cnt;

   assign fail_cnt = access_fails + stable_fails + ready_fails;

   // an access phase always follows a registered setup
   a_access_dv: assert property (@(posedge PCLK) disable iff (!PRESETn)
      (PSEL && PENABLE) |-> dv)
      else begin
         $error("access phase without dv");
         access_fails++;
      end

   // master keeps address and direction during wait states
   a_held_stable: assert property (@(posedge PCLK) disable iff (!PRESETn)
      (PSEL && PENABLE && !PREADY) |=> ($stable(PADDR) && $stable(PWRITE)))
      else begin
         $error("PADDR or PWRITE changed in a held access");
         stable_fails++;
      end

   // idle bus never stalls and has no open request
   a_idle_ready: assert property (@(posedge PCLK) disable iff (!PRESETn)
      !PSEL |-> (PREADY && !dv))
      else begin
         $error("PREADY low or dv high while PSEL is low");
         ready_fails++;
      end

endmodule

bind apb_slv_sif csum_assert u_assert (
   .PCLK    (PCLK),
   .PRESETn (PRESETn),
   .PSEL    (PSEL),
   .PENABLE (PENABLE),
   .PADDR   (PADDR),
   .PWRITE  (PWRITE),
   .PREADY  (PREADY),
   .dv      (dv)
);

/* dv/csum_tb.sv */
/*
  Testbench for the APB Fletcher-16 peripheral. APB inputs change on the
  falling edge, and responses are sampled 1 ns later, between the edges.
  Random stimulus comes from a fixed seed and is checked against a local
  model of the scratch words, both Fletcher sums and the word count.
*/

`timescale 1ns/1ns

module csum_tb;

   localparam int TIMEOUT = 50;

   logic                       PCLK;
   logic                       PRESETn;
   logic [apb_pkg::ADDR_W-1:0] PADDR;
   logic [2:0]                 PPROT;
   logic                       PSEL;
   logic                       PENABLE;
   logic                       PWRITE;
   logic [apb_pkg::DATA_W-1:0] PWDATA;
   logic [apb_pkg::USER_W-1:0] PAUSER;
   logic                       PREADY;
   logic                       PSLVERR;
   logic [apb_pkg::DATA_W-1:0] PRDATA;

   // error counters
   int value_errs;
   int resp_errs;
   int timeouts;

   // reference model
   logic [31:0] m_scr [4];
   int          m_sum1;
   int          m_sum2;
   int          m_count;

   integer      seed;
   logic [31:0] rd;
   logic [31:0] wd;
   logic        serr;
   int          nwait;
   int          held;
   int          n;
   logic [1:0]  idx;
   logic [11:0] addr;

   apb_csum_top i_dut (.*);

   initial begin
      PCLK = 1'b0;
      forever #2 PCLK = ~PCLK;
   end

   task automatic print_counts();
      $display("errors: value %0d, response %0d, timeout %0d, assertion %0d",
               value_errs, resp_errs, timeouts, i_dut.u_sif.u_assert.fail_cnt);
   endtask

   task automatic report_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
      value_errs++;
      $display("FAILED %0t: %s read %h, expected %h", $time, what, got, exp);
   endtask

   task automatic report_resp(input string what, input logic got, input logic exp);
      resp_errs++;
      $display("FAILED %0t: %s gave PSLVERR %b, expected %b", $time, what, got, exp);
   endtask

   // one APB transfer, bus left in access phase for a back-to-back follower
   task automatic apb_xfer(input logic wr, input logic [11:0] a, input logic [31:0] wdata,
                           input logic [3:0] user, output logic [31:0] rdata,
                           output logic err, output int waits);
      int cnt;
      @(negedge PCLK);
      PSEL    = 1'b1;
      PENABLE = 1'b0;
      PWRITE  = wr;
      PADDR   = a;
      PWDATA  = wdata;
      PAUSER  = user;
      PPROT   = 3'($random(seed));
      @(negedge PCLK);
      PENABLE = 1'b1;
      #1;
      cnt = 0;
      // each low PREADY sample is one wait state
      while (PREADY !== 1'b1 && cnt < TIMEOUT) begin
         @(negedge PCLK);
         #1;
         cnt++;
      end
      if (PREADY !== 1'b1) begin
         timeouts++;
         $display("timeout: PREADY stayed low for %0d cycles at address %h, time %0t",
                  TIMEOUT, a, $time);
         print_counts();
         $display("Test failed");
         $finish;
      end else begin
         rdata = PRDATA;
         err   = PSLVERR;
         waits = cnt;
      end
   endtask

   task automatic read_expect(input logic [11:0] a, input logic [31:0] exp, input string what);
      logic [31:0] got;
      logic        err;
      int          waits;
      apb_xfer(1'b0, a, 32'h0, 4'h0, got, err, waits);
      if (err !== 1'b0) begin
         report_resp(what, err, 1'b0);
      end
      if (got !== exp) begin
         report_value(what, got, exp);
      end
   endtask

   task automatic go_idle();
      @(negedge PCLK);
      PSEL    = 1'b0;
      PENABLE = 1'b0;
   endtask

   // Fletcher-16 over four bytes, least significant first
   task automatic model_fold(input logic [31:0] w);
      int i;
      for (i = 0; i < 4; i++) begin
         m_sum1 = (m_sum1 + int'(w[8*i +: 8])) % 255;
         m_sum2 = (m_sum2 + m_sum1) % 255;
      end
      m_count++;
   endtask

   function automatic logic [11:0] scr_addr(input logic [1:0] i);
      return csum_pkg::OFS_SCR0 + {8'h00, i, 2'b00};
   endfunction

   function automatic logic [31:0] result_word();
      return {16'h0000, 8'(m_sum2), 8'(m_sum1)};
   endfunction

   function automatic logic [31:0] status_word(input logic busy);
      return {busy, 15'h0000, 16'(m_count)};
   endfunction

   initial begin
      seed       = 32'hcd8a3451;
      value_errs = 0;
      resp_errs  = 0;
      timeouts   = 0;
      m_scr      = '{default: '0};
      m_sum1     = 0;
      m_sum2     = 0;
      m_count    = 0;
      PRESETn    = 1'b0;
      PSEL       = 1'b0;
      PENABLE    = 1'b0;
      PWRITE     = 1'b0;
      PADDR      = '0;
      PWDATA     = '0;
      PAUSER     = '0;
      PPROT      = '0;
      repeat (3) @(posedge PCLK);
      @(negedge PCLK);
      PRESETn = 1'b1;

      // reset state, idle bus must show PREADY
      @(negedge PCLK);
      #1;
      if (PREADY !== 1'b1) begin
         report_value("PREADY while idle", {31'h0, PREADY}, 32'h1);
      end
      read_expect(csum_pkg::OFS_RESULT, 32'h0, "RESULT after reset");
      read_expect(csum_pkg::OFS_STATUS, 32'h0, "STATUS after reset");
      for (n = 0; n < 4; n++) begin
         read_expect(scr_addr(2'(n)), 32'h0, "scratch after reset");
      end

      // scratch writes with random low address bits, interleaved read-back
      for (n = 0; n < 24; n++) begin
         idx  = 2'($random(seed));
         wd   = $random(seed);
         addr = scr_addr(idx) | 12'($random(seed) & 3);
         apb_xfer(1'b1, addr, wd, 4'($random(seed)), rd, serr, nwait);
         if (serr !== 1'b0) begin
            report_resp("scratch write", serr, 1'b0);
         end
         m_scr[idx] = wd;
         idx = 2'($random(seed));
         read_expect(scr_addr(idx), m_scr[idx], "scratch read-back");
      end

      // DATA words back to back, later ones wait on the busy engine
      held = 0;
      for (n = 0; n < 8; n++) begin
         wd = $random(seed);
         apb_xfer(1'b1, csum_pkg::OFS_DATA, wd, 4'($random(seed)), rd, serr, nwait);
         if (serr !== 1'b0) begin
            report_resp("DATA write", serr, 1'b0);
         end
         held = held + nwait;
         model_fold(wd);
      end
      if (held == 0) begin
         value_errs++;
         $display("no DATA write was held while the engine was busy, time %0t", $time);
      end
      read_expect(csum_pkg::OFS_RESULT, result_word(), "RESULT after DATA words");
      read_expect(csum_pkg::OFS_STATUS, status_word(1'b0), "STATUS after DATA words");

      // STATUS right behind a DATA write lands in the busy window
      wd = $random(seed);
      apb_xfer(1'b1, csum_pkg::OFS_DATA, wd, 4'h0, rd, serr, nwait);
      read_expect(csum_pkg::OFS_STATUS, status_word(1'b1), "STATUS while busy");
      model_fold(wd);
      read_expect(csum_pkg::OFS_RESULT, result_word(), "RESULT after busy word");

      // clear without privilege is rejected
      apb_xfer(1'b1, csum_pkg::OFS_CTRL, 32'h1, 4'($random(seed)) & 4'he, rd, serr, nwait);
      if (serr !== 1'b1) begin
         report_resp("unprivileged CTRL write", serr, 1'b1);
      end
      read_expect(csum_pkg::OFS_RESULT, result_word(), "RESULT after rejected clear");
      read_expect(csum_pkg::OFS_STATUS, status_word(1'b0), "STATUS after rejected clear");
      apb_xfer(1'b1, csum_pkg::OFS_CTRL, 32'h1, 4'($random(seed)) | 4'h1, rd, serr, nwait);
      if (serr !== 1'b0) begin
         report_resp("privileged CTRL write", serr, 1'b0);
      end
      m_sum1  = 0;
      m_sum2  = 0;
      m_count = 0;
      read_expect(csum_pkg::OFS_RESULT, result_word(), "RESULT after clear");
      read_expect(csum_pkg::OFS_STATUS, status_word(1'b0), "STATUS after clear");

      // error transfers on a non-zero state
      wd = $random(seed);
      apb_xfer(1'b1, csum_pkg::OFS_DATA, wd, 4'h0, rd, serr, nwait);
      model_fold(wd);
      for (n = 0; n < 6; n++) begin
         addr = 12'h020 + 12'({$random(seed)} % 4064);
         apb_xfer(1'b1, addr, $random(seed), 4'hf, rd, serr, nwait);
         if (serr !== 1'b1) begin
            report_resp("unmapped write", serr, 1'b1);
         end
         apb_xfer(1'b0, addr, 32'h0, 4'hf, rd, serr, nwait);
         if (serr !== 1'b1) begin
            report_resp("unmapped read", serr, 1'b1);
         end
      end
      apb_xfer(1'b0, csum_pkg::OFS_DATA, 32'h0, 4'hf, rd, serr, nwait);
      if (serr !== 1'b1) begin
         report_resp("DATA read", serr, 1'b1);
      end
      apb_xfer(1'b0, csum_pkg::OFS_CTRL, 32'h0, 4'hf, rd, serr, nwait);
      if (serr !== 1'b1) begin
         report_resp("CTRL read", serr, 1'b1);
      end
      apb_xfer(1'b1, csum_pkg::OFS_RESULT, $random(seed), 4'hf, rd, serr, nwait);
      if (serr !== 1'b1) begin
         report_resp("RESULT write", serr, 1'b1);
      end
      apb_xfer(1'b1, csum_pkg::OFS_STATUS, $random(seed), 4'hf, rd, serr, nwait);
      if (serr !== 1'b1) begin
         report_resp("STATUS write", serr, 1'b1);
      end
      read_expect(csum_pkg::OFS_RESULT, result_word(), "RESULT after error transfers");
      read_expect(csum_pkg::OFS_STATUS, status_word(1'b0), "STATUS after error transfers");
      for (n = 0; n < 4; n++) begin
         read_expect(scr_addr(2'(n)), m_scr[2'(n)], "scratch after error transfers");
      end

      go_idle();
      @(negedge PCLK);
      print_counts();
      if (value_errs + resp_errs + timeouts + i_dut.u_sif.u_assert.fail_cnt == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* all.f */
hdl/apb_pkg.sv
hdl/csum_pkg.sv
hdl/apb_slv_sif.sv
hdl/csum_reg_ctrl.sv
hdl/fletcher_engine.sv
hdl/scratch_regs.sv
hdl/apb_csum_top.sv
dv/csum_assert.sv
dv/csum_tb.sv

/* Makefile */
TOP = csum_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)
	verilator --lint-only -f all.f --top-module apb_csum_top

sim:
	verilator --binary --assert -f all.f --top-module $(TOP) -o V$(TOP)
	out=$$(./obj_dir/V$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Test passed$$"

clean:
	rm -rf obj_dir
